/* hw/bitmanip_types_pkg.sv */
`default_nettype none

package bitmanip_types_pkg;

  // data path ---------------------------------------
  // byte lanes and the clmul product split assume 4 bytes
  localparam int XLEN = 32;

  // register value, one data word
  typedef logic [XLEN-1:0] xword_t;

  // shift amount / bit index into a word
  typedef logic [$clog2(XLEN)-1:0] shamt_t;

  // bit count 0..XLEN, one bit wider than shamt
  typedef logic [$clog2(XLEN):0] bcnt_t;

  // full carry-less product
  typedef logic [2*XLEN-1:0] dword_t;

  // instruction fields ------------------------------
  typedef struct packed {
    logic [11:0] funct12; // funct7 + rs2 field, or imm[11:0]
    logic [2:0]  funct3;
    logic        opcode5; // 1: register form (OP), 0: immediate form (OP-IMM)
  } instr_fields_t;

endpackage

`default_nettype wire

/* hw/bitmanip_op_pkg.sv */
`default_nettype none

package bitmanip_op_pkg;
  import bitmanip_types_pkg::*;

  // operations --------------------------------------
  typedef enum logic [4:0] {
    OP_NONE,                               // no match, result zero
    OP_ANDN, OP_ORN, OP_XNOR,              // zbb logic with negate
    OP_CLZ, OP_CTZ, OP_CPOP,               // zbb counts
    OP_MAX, OP_MIN,                        // signed/unsigned by less
    OP_SEXTB, OP_SEXTH, OP_ZEXTH,          // extension
    OP_ROL, OP_ROR,                        // ror also rori
    OP_ORCB, OP_REV8,
    OP_SH1ADD, OP_SH2ADD, OP_SH3ADD,       // zba
    OP_BCLR, OP_BEXT, OP_BINV, OP_BSET,    // zbs
    OP_CLMUL, OP_CLMULH, OP_CLMULR         // zbc
  } bm_op_t;

  // unit that finishes an op
  typedef enum logic [1:0] {UNIT_SINGLE, UNIT_SHIFT, UNIT_CLMUL} unit_t;

  typedef enum logic [2:0] {
    S_IDLE,
    S_START_SHIFT,
    S_BUSY_SHIFT,
    S_START_CLMUL,
    S_BUSY_CLMUL
  } ctrl_state_t;

  // captured operation, held stable while a unit runs
  typedef struct packed {
    bm_op_t op;
    xword_t rs1;
    xword_t rs2;
    shamt_t shamt;
    logic   less;  // cpu comparator, rs1 < rs2
  } bm_operands_t;

  function automatic unit_t op_unit_f(input bm_op_t op);
    case (op)
      OP_ROL, OP_ROR, OP_CLZ, OP_CTZ, OP_CPOP: return UNIT_SHIFT;
      OP_CLMUL, OP_CLMULH, OP_CLMULR:         return UNIT_CLMUL;
      default:                                return UNIT_SINGLE; // incl. OP_NONE
    endcase
  endfunction

endpackage

`default_nettype wire

/* hw/bitmanip_decoder.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_decoder
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  instr_fields_t instr_i,
  output bm_op_t        op_o
);

  logic [1:0] grp;   // funct12[10:9], picks the instruction group
  logic       f12_7; // funct7[2]
  logic       f12_5; // funct7[0]
  logic [2:0] f3;

  assign grp   = instr_i.funct12[10:9];
  assign f12_7 = instr_i.funct12[7];
  assign f12_5 = instr_i.funct12[5];
  assign f3    = instr_i.funct3;

  // minimal decode, cpu has already checked legality
  always_comb begin
    op_o = OP_NONE;
    case (grp)
      2'b00: begin // zext.h, min/max, clmul*
        if (!f12_5) op_o = OP_ZEXTH;
        else if (f3[2]) op_o = f3[1] ? OP_MAX : OP_MIN;
        else begin
          case (f3[1:0])
            2'b01:   op_o = OP_CLMUL;
            2'b10:   op_o = OP_CLMULR;
            2'b11:   op_o = OP_CLMULH;
            default: op_o = OP_NONE;
          endcase
        end
      end
      2'b01: begin // shNadd, bset, orc.b
        if (f12_7) begin
          if (f3 == 3'b101) op_o = OP_ORCB;
          else if (!f3[2]) op_o = OP_BSET;
        end else begin
          case (f3[2:1])
            2'b01:   op_o = OP_SH1ADD;
            2'b10:   op_o = OP_SH2ADD;
            2'b11:   op_o = OP_SH3ADD;
            default: op_o = OP_NONE;
          endcase
        end
      end
      2'b10: begin // andn/orn/xnor, bclr/bext
        if (f12_7) op_o = f3[2] ? OP_BEXT : OP_BCLR;
        else if (f3[1:0] == 2'b11) op_o = OP_ANDN;
        else if (f3[1:0] == 2'b10) op_o = OP_ORN;
        else if (f3[1:0] == 2'b00) op_o = OP_XNOR;
      end
      default: begin // rotates, counts, sext, rev8, binv
        if (f12_7) begin
          if (f3 == 3'b101) op_o = OP_REV8;
          else if (!f3[2]) op_o = OP_BINV;
        end else if (f3 == 3'b101) op_o = OP_ROR;        // ror and rori
        else if (f3 == 3'b001 && instr_i.opcode5) op_o = OP_ROL;
        else if (!instr_i.opcode5 && !f3[2]) begin
          case (instr_i.funct12[2:0])                     // rs2 field selects
            3'b000:  op_o = OP_CLZ;
            3'b001:  op_o = OP_CTZ;
            3'b010:  op_o = OP_CPOP;
            3'b100:  op_o = OP_SEXTB;
            3'b101:  op_o = OP_SEXTH;
            default: op_o = OP_NONE;
          endcase
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* hw/bitmanip_ctrl.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_ctrl
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         start_i,
  input  bm_op_t       op_i,
  input  xword_t       rs1_i,
  input  xword_t       rs2_i,
  input  shamt_t       shamt_i,
  input  logic         less_i,
  input  logic         shift_busy_i,
  input  logic         clmul_busy_i,
  output bm_operands_t opnd_o,
  output logic         shift_start_o,
  output logic         clmul_start_o,
  output logic         done_o
);

  ctrl_state_t state_q;
  unit_t       unit;   // where the decoded op goes
  logic        accept; // strobe taken

  assign unit   = op_unit_f(op_i);
  assign accept = start_i && (state_q == S_IDLE);

  // operand capture ---------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      opnd_o.op    <= op_i;
      opnd_o.rs1   <= rs1_i;
      opnd_o.rs2   <= rs2_i;
      opnd_o.shamt <= shamt_i;
      opnd_o.less  <= less_i;
    end
  end

  // fsm ---------------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      state_q       <= S_IDLE;
      shift_start_o <= 1'b0;
      clmul_start_o <= 1'b0;
      done_o        <= 1'b0;
    end else begin
      shift_start_o <= 1'b0; // all pulses
      clmul_start_o <= 1'b0;
      done_o        <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (accept) begin
            case (unit)
              UNIT_SHIFT: begin
                shift_start_o <= 1'b1;
                state_q       <= S_START_SHIFT;
              end
              UNIT_CLMUL: begin
                clmul_start_o <= 1'b1;
                state_q       <= S_START_CLMUL;
              end
              default: done_o <= 1'b1; // single-cycle, result next cycle
            endcase
          end
        end
        S_START_SHIFT: state_q <= S_BUSY_SHIFT; // unit loads this cycle
        S_BUSY_SHIFT: begin
          if (!shift_busy_i) begin
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        S_START_CLMUL: state_q <= S_BUSY_CLMUL;
        S_BUSY_CLMUL: begin
          if (!clmul_busy_i) begin
            done_o  <= 1'b1;
            state_q <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // checks ------------------------------------------
  // env must wait for valid before the next strobe
  assert property (@(posedge clk_i) disable iff (!rstn_i) start_i |-> state_q == S_IDLE)
    else $error("start_i while busy");

  // one completion per op
  assert property (@(posedge clk_i) disable iff (!rstn_i) done_o |=> !done_o)
    else $error("done_o held for two cycles");

endmodule

`default_nettype wire

/* hw/bitmanip_serial_shifter.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_serial_shifter
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         start_i,
  input  bm_operands_t opnd_i,
  output logic         busy_o,
  output xword_t       res_o
);

  xword_t sreg_q;      // rotates right by one per step
  bcnt_t  cnt_q;       // steps done
  bcnt_t  cnt_max_q;   // shamt, or XLEN for counts
  bcnt_t  bcnt_q;      // ones seen, cpop
  logic   active_q;
  logic   rev_in;      // clz/rol run on the reversed word
  logic   zcount;      // clz or ctz
  logic   stop;
  xword_t rs1_rev;
  xword_t sreg_rev;

  assign rs1_rev  = {<<{opnd_i.rs1}};
  assign sreg_rev = {<<{sreg_q}};
  assign rev_in   = (opnd_i.op == OP_CLZ) || (opnd_i.op == OP_ROL);
  assign zcount   = (opnd_i.op == OP_CLZ) || (opnd_i.op == OP_CTZ);

  // zero count ends on the first one, zero operand ends at XLEN
  assign stop   = (cnt_q == cnt_max_q) || (zcount && sreg_q[0]);
  assign busy_o = active_q && !stop;

  // control -----------------------------------------
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      active_q  <= 1'b0;
      cnt_q     <= '0;
      cnt_max_q <= '0;
      bcnt_q    <= '0;
    end else if (start_i) begin
      active_q <= 1'b1;
      cnt_q    <= '0;
      bcnt_q   <= '0;
      if (opnd_i.op == OP_ROL || opnd_i.op == OP_ROR)
        cnt_max_q <= {1'b0, opnd_i.shamt};
      else
        cnt_max_q <= bcnt_t'(XLEN);   // cpop, clz, ctz
    end else if (busy_o) begin
      cnt_q  <= cnt_q + 1'b1;
      bcnt_q <= bcnt_q + bcnt_t'(sreg_q[0]);
    end else begin
      active_q <= 1'b0;              // done, hold result
    end
  end

  // data, right rotates only
  always_ff @(posedge clk_i) begin
    if (start_i) sreg_q <= rev_in ? rs1_rev : opnd_i.rs1;
    else if (busy_o) sreg_q <= {sreg_q[0], sreg_q[XLEN-1:1]};
  end

  always_comb begin
    case (opnd_i.op)
      OP_ROR:         res_o = sreg_q;
      OP_ROL:         res_o = sreg_rev; // undo input reversal
      OP_CLZ, OP_CTZ: res_o = xword_t'(cnt_q);
      OP_CPOP:        res_o = xword_t'(bcnt_q);
      default:        res_o = '0;
    endcase
  end

  // longest run is cpop, XLEN steps after the load
  assert property (@(posedge clk_i) disable iff (!rstn_i) start_i |-> ##[1:33] !busy_o)
    else $error("shifter busy too long");

endmodule

`default_nettype wire

/* hw/bitmanip_clmul.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_clmul
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  logic         clk_i,
  input  logic         rstn_i,
  input  logic         start_i,
  input  bm_operands_t opnd_i,
  output logic         busy_o,
  output xword_t       res_o
);

  dword_t prod_q;   // hi: accumulator, lo: multiplier bits left
  bcnt_t  cnt_q;    // steps left
  logic   rev;      // clmulr works on reversed operands
  xword_t rs1_rev;
  xword_t rs2_rev;
  xword_t rs2_op;
  xword_t acc;
  xword_t lo_rev;

  assign rev     = (opnd_i.op == OP_CLMULR);
  assign rs1_rev = {<<{opnd_i.rs1}};
  assign rs2_rev = {<<{opnd_i.rs2}};
  assign rs2_op  = rev ? rs2_rev : opnd_i.rs2;
  assign acc     = prod_q[2*XLEN-1:XLEN] ^ (prod_q[0] ? rs2_op : '0); // add if lsb set
  assign lo_rev  = {<<{prod_q[XLEN-1:0]}};
  assign busy_o  = |cnt_q;

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) cnt_q <= '0;
    else if (start_i) cnt_q <= bcnt_t'(XLEN);
    else if (busy_o) cnt_q <= cnt_q - 1'b1;
  end

  // shift-and-xor, one multiplier bit per step
  always_ff @(posedge clk_i) begin
    if (start_i) prod_q <= {{XLEN{1'b0}}, (rev ? rs1_rev : opnd_i.rs1)};
    else if (busy_o) prod_q <= {1'b0, acc, prod_q[XLEN-1:1]};
  end

  always_comb begin
    case (opnd_i.op)
      OP_CLMUL:  res_o = prod_q[XLEN-1:0];
      OP_CLMULH: res_o = prod_q[2*XLEN-1:XLEN];
      OP_CLMULR: res_o = lo_rev;   // = product bits 62:31
      default:   res_o = '0;
    endcase
  end

endmodule

`default_nettype wire

/* hw/bitmanip_result_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_result_stage
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  logic         clk_i,
  input  logic         rstn_i,
  input  bm_operands_t opnd_i,
  input  logic         done_i,
  input  xword_t       shift_res_i,
  input  xword_t       clmul_res_i,
  output xword_t       res_o,
  output logic         valid_o
);

  xword_t rs1;
  xword_t rs2;
  xword_t onehot;   // bit shamt set
  xword_t addend;   // rs1 << 1..3
  xword_t sum;
  xword_t minmax;
  xword_t orcb;
  xword_t rev8;
  xword_t sel;
  logic   is_max;

  assign rs1    = opnd_i.rs1;
  assign rs2    = opnd_i.rs2;
  assign onehot = xword_t'(1) << opnd_i.shamt;

  // shifted add ---------------------------------------
  always_comb begin
    case (opnd_i.op)
      OP_SH1ADD: addend = rs1 << 1;
      OP_SH2ADD: addend = rs1 << 2;
      default:   addend = rs1 << 3;
    endcase
  end
  assign sum = rs2 + addend; // wraps mod 2^XLEN

  // min/max, less already signed or unsigned
  assign is_max = (opnd_i.op == OP_MAX);
  assign minmax = (opnd_i.less ^ is_max) ? rs1 : rs2;

  // byte ops
  always_comb begin
    for (int b = 0; b < XLEN/8; b++) begin
      orcb[8*b +: 8] = {8{|rs1[8*b +: 8]}};
      rev8[8*b +: 8] = rs1[XLEN-8-8*b +: 8];  // byte swap
    end
  end

  // select ------------------------------------------
  always_comb begin
    case (opnd_i.op)
      OP_ANDN:                     sel = rs1 & ~rs2;
      OP_ORN:                      sel = rs1 | ~rs2;
      OP_XNOR:                     sel = rs1 ^ ~rs2;
      OP_MIN, OP_MAX:              sel = minmax;
      OP_SEXTB:                    sel = {{(XLEN-8){rs1[7]}}, rs1[7:0]};
      OP_SEXTH:                    sel = {{(XLEN-16){rs1[15]}}, rs1[15:0]};
      OP_ZEXTH:                    sel = {{(XLEN-16){1'b0}}, rs1[15:0]};
      OP_ORCB:                     sel = orcb;
      OP_REV8:                     sel = rev8;
      OP_SH1ADD, OP_SH2ADD, OP_SH3ADD: sel = sum;
      OP_BCLR:                     sel = rs1 & ~onehot;
      OP_BSET:                     sel = rs1 | onehot;
      OP_BINV:                     sel = rs1 ^ onehot;
      OP_BEXT:                     sel = {{(XLEN-1){1'b0}}, |(rs1 & onehot)};
      OP_ROL, OP_ROR, OP_CLZ, OP_CTZ, OP_CPOP: sel = shift_res_i;
      OP_CLMUL, OP_CLMULH, OP_CLMULR:          sel = clmul_res_i;
      default:                     sel = '0;  // OP_NONE
    endcase
  end

  // output register, zero between results
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      res_o   <= '0;
      valid_o <= 1'b0;
    end else begin
      valid_o <= done_i;
      res_o   <= done_i ? sel : '0;
    end
  end

endmodule

`default_nettype wire

/* hw/bitmanip_top.sv */
`timescale 1ns/10ps
`default_nettype none

module bitmanip_top
  import bitmanip_types_pkg::*;
  import bitmanip_op_pkg::*;
(
  input  logic          clk_i,
  input  logic          rstn_i,
  input  logic          start_i,      // one-cycle strobe
  input  instr_fields_t instr_i,
  input  xword_t        rs1_i,
  input  xword_t        rs2_i,
  input  shamt_t        shamt_i,
  input  logic          less_i,       // from cpu comparator
  output xword_t        res_o,
  output logic          valid_o
);

  bm_op_t       op;
  bm_operands_t opnd;         // captured op and operands
  logic         shift_start;
  logic         clmul_start;
  logic         done;
  logic         shift_busy;
  logic         clmul_busy;
  xword_t       shift_res;
  xword_t       clmul_res;

  bitmanip_decoder u_decoder (
    .instr_i (instr_i),
    .op_o    (op)
  );

  bitmanip_ctrl u_ctrl (
    .clk_i         (clk_i),
    .rstn_i        (rstn_i),
    .start_i       (start_i),
    .op_i          (op),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .shamt_i       (shamt_i),
    .less_i        (less_i),
    .shift_busy_i  (shift_busy),
    .clmul_busy_i  (clmul_busy),
    .opnd_o        (opnd),
    .shift_start_o (shift_start),
    .clmul_start_o (clmul_start),
    .done_o        (done)
  );

  bitmanip_serial_shifter u_shifter (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (shift_start),
    .opnd_i  (opnd),
    .busy_o  (shift_busy),
    .res_o   (shift_res)
  );

  bitmanip_clmul u_clmul (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .start_i (clmul_start),
    .opnd_i  (opnd),
    .busy_o  (clmul_busy),
    .res_o   (clmul_res)
  );

  bitmanip_result_stage u_result (
    .clk_i       (clk_i),
    .rstn_i      (rstn_i),
    .opnd_i      (opnd),
    .done_i      (done),
    .shift_res_i (shift_res),
    .clmul_res_i (clmul_res),
    .res_o       (res_o),
    .valid_o     (valid_o)
  );

endmodule

`default_nettype wire

/* test/tb_bitmanip_model.svh */
`ifndef TB_BITMANIP_MODEL_SVH
`define TB_BITMANIP_MODEL_SVH

// ops driven by the testbench, t_illegal decodes to nothing
typedef enum int {
  T_ANDN, T_ORN, T_XNOR, T_SEXTB, T_SEXTH, T_ZEXTH, T_ORCB, T_REV8,
  T_SH1ADD, T_SH2ADD, T_SH3ADD,
  T_BCLR, T_BSET, T_BINV, T_BEXT, T_MIN, T_MAX, T_MINU, T_MAXU,
  T_ROL, T_ROR, T_CLZ, T_CTZ, T_CPOP,
  T_CLMUL, T_CLMULH, T_CLMULR, T_ILLEGAL
} tb_op_t;

// encoding ----------------------------------------
// {funct7, rs2 field, funct3, opcode bit 5}
function automatic instr_fields_t encode_op(input tb_op_t t);
  case (t)
    T_ANDN:   return {7'b0100000, 5'd0, 3'b111, 1'b1};
    T_ORN:    return {7'b0100000, 5'd0, 3'b110, 1'b1};
    T_XNOR:   return {7'b0100000, 5'd0, 3'b100, 1'b1};
    T_SEXTB:  return {7'b0110000, 5'd4, 3'b001, 1'b0};  // op-imm
    T_SEXTH:  return {7'b0110000, 5'd5, 3'b001, 1'b0};
    T_ZEXTH:  return {7'b0000100, 5'd0, 3'b100, 1'b1};
    T_ORCB:   return {7'b0010100, 5'd7, 3'b101, 1'b0};
    T_REV8:   return {7'b0110100, 5'd24, 3'b101, 1'b0}; // rv32 form
    T_SH1ADD: return {7'b0010000, 5'd0, 3'b010, 1'b1};
    T_SH2ADD: return {7'b0010000, 5'd0, 3'b100, 1'b1};
    T_SH3ADD: return {7'b0010000, 5'd0, 3'b110, 1'b1};
    T_BCLR:   return {7'b0100100, 5'd0, 3'b001, 1'b1};
    T_BSET:   return {7'b0010100, 5'd0, 3'b001, 1'b1};
    T_BINV:   return {7'b0110100, 5'd0, 3'b001, 1'b1};
    T_BEXT:   return {7'b0100100, 5'd0, 3'b101, 1'b1};
    T_MIN:    return {7'b0000101, 5'd0, 3'b100, 1'b1};
    T_MAX:    return {7'b0000101, 5'd0, 3'b110, 1'b1};
    T_MINU:   return {7'b0000101, 5'd0, 3'b101, 1'b1};
    T_MAXU:   return {7'b0000101, 5'd0, 3'b111, 1'b1};
    T_ROL:    return {7'b0110000, 5'd0, 3'b001, 1'b1};
    T_ROR:    return {7'b0110000, 5'd0, 3'b101, 1'b1};
    T_CLZ:    return {7'b0110000, 5'd0, 3'b001, 1'b0};
    T_CTZ:    return {7'b0110000, 5'd1, 3'b001, 1'b0};
    T_CPOP:   return {7'b0110000, 5'd2, 3'b001, 1'b0};
    T_CLMUL:  return {7'b0000101, 5'd0, 3'b001, 1'b1};
    T_CLMULR: return {7'b0000101, 5'd0, 3'b010, 1'b1};
    T_CLMULH: return {7'b0000101, 5'd0, 3'b011, 1'b1};
    default:  return {7'b0000101, 5'd0, 3'b000, 1'b1}; // unused slot
  endcase
endfunction

// reference model ---------------------------------
function automatic xword_t model_result(input tb_op_t t, input xword_t a, input xword_t b,
                                        input shamt_t s);
  dword_t p;
  xword_t r;
  int     i;
  p = '0;
  r = '0;
  for (i = 0; i < 32; i++) begin
    if (b[i]) p = p ^ (dword_t'(a) << i); // carry-less, xor instead of add
  end
  case (t)
    T_ANDN:   r = a & ~b;
    T_ORN:    r = a | ~b;
    T_XNOR:   r = ~(a ^ b);
    T_SEXTB:  r = {{24{a[7]}}, a[7:0]};
    T_SEXTH:  r = {{16{a[15]}}, a[15:0]};
    T_ZEXTH:  r = {16'h0000, a[15:0]};
    T_ORCB: begin
      for (i = 0; i < 4; i++) r[8*i +: 8] = (a[8*i +: 8] != 8'h00) ? 8'hff : 8'h00;
    end
    T_REV8:   r = {a[7:0], a[15:8], a[23:16], a[31:24]};
    T_SH1ADD: r = b + (a << 1);
    T_SH2ADD: r = b + (a << 2);
    T_SH3ADD: r = b + (a << 3);
    T_BCLR:   r = a & ~(32'h1 << s);
    T_BSET:   r = a | (32'h1 << s);
    T_BINV:   r = a ^ (32'h1 << s);
    T_BEXT:   r = (a >> s) & 32'h1;
    T_MIN:    r = ($signed(a) < $signed(b)) ? a : b;
    T_MAX:    r = ($signed(a) < $signed(b)) ? b : a;
    T_MINU:   r = (a < b) ? a : b;
    T_MAXU:   r = (a < b) ? b : a;
    T_ROL:    r = (a << s) | (a >> (32 - s)); // shift by 32 gives zero
    T_ROR:    r = (a >> s) | (a << (32 - s));
    T_CLZ: begin
      r = 32;
      for (i = 0; i < 32; i++) if (a[i]) r = 31 - i; // highest one wins
    end
    T_CTZ: begin
      r = 32;
      for (i = 31; i >= 0; i--) if (a[i]) r = i;     // lowest one wins
    end
    T_CPOP: begin
      for (i = 0; i < 32; i++) r = r + a[i];
    end
    T_CLMUL:  r = p[31:0];
    T_CLMULH: r = p[63:32];
    T_CLMULR: r = p[62:31];
    default:  r = '0;
  endcase
  return r;
endfunction

`endif

/* test/tb_bitmanip.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_bitmanip
  import bitmanip_types_pkg::*;
();

  `include "tb_bitmanip_model.svh"

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int ROUNDS       = 8;  // random operand sets per op
  localparam int MAX_WAIT     = 40; // cycles from start to valid
  localparam int NUM_OPS      = 28 * ROUNDS + 10; // 10 edge operands in test 4

  logic          clk;
  logic          rstn;
  logic          start;
  instr_fields_t instr;
  xword_t        rs1;
  xword_t        rs2;
  shamt_t        shamt;
  logic          less;
  xword_t        res;
  logic          valid;

  logic [31:0] rng;
  int          checks;
  int          errors;
  int          valid_seen;  // pulses counted by the monitor
  int          checks_mark;
  int          errors_mark;

  bitmanip_top dut0 (
    .clk_i   (clk),
    .rstn_i  (rstn),
    .start_i (start),
    .instr_i (instr),
    .rs1_i   (rs1),
    .rs2_i   (rs2),
    .shamt_i (shamt),
    .less_i  (less),
    .res_o   (res),
    .valid_o (valid)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // helpers -----------------------------------------
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // cpu comparator, funct3[0] picks unsigned
  function automatic logic cpu_less(input instr_fields_t f, input xword_t a, input xword_t b);
    return f.funct3[0] ? (a < b) : ($signed(a) < $signed(b));
  endfunction

  task automatic check_value(input string what, input xword_t got, input xword_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error at %0t ns: %s gave %08h, expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic run_op(input tb_op_t t, input xword_t a, input xword_t b, input shamt_t s);
    xword_t exp;
    int     cycles;
    exp = model_result(t, a, b, s);
    @(negedge clk);
    instr = encode_op(t);
    rs1   = a;
    rs2   = b;
    shamt = s;
    less  = cpu_less(encode_op(t), a, b);
    start = 1'b1;
    cycles = 0;
    do begin
      @(negedge clk);
      start = 1'b0;
      cycles++;
    end while (!valid && cycles < MAX_WAIT);
    if (!valid) begin
      errors++;
      $display("%s gave no valid_o within %0d cycles", t.name(), MAX_WAIT);
    end else begin
      check_value(t.name(), res, exp);
      if (t < T_ROL || t == T_ILLEGAL)  // single-cycle path
        check_value({t.name(), " latency"}, cycles, 2);
    end
  endtask

  task automatic rand_op(input tb_op_t t);
    xword_t a;
    xword_t b;
    rng = xorshift32(rng);
    a   = rng;
    rng = xorshift32(rng);
    b   = rng;
    rng = xorshift32(rng);
    run_op(t, a, b, rng[4:0]);
  endtask

  task automatic begin_test();
    checks_mark = checks;
    errors_mark = errors;
  endtask

  task automatic end_test(input string name);
    $display("test %s: %0d checks, %0d errors", name, checks - checks_mark,
             errors - errors_mark);
  endtask

  // idle output and pulse count, every cycle
  always @(negedge clk) begin
    if (rstn) begin
      if (valid) valid_seen++;
      else check_value("idle res_o", res, '0);
    end
  end

  // stimulus ----------------------------------------
  initial begin
    int r;
    int k;
    rng        = 32'hd989_953e;
    checks     = 0;
    errors     = 0;
    valid_seen = 0;
    rstn       = 1'b0;
    start      = 1'b0;
    instr      = '0;
    rs1        = '0;
    rs2        = '0;
    shamt      = '0;
    less       = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    begin_test();
    for (r = 0; r < ROUNDS; r++)
      for (k = T_ANDN; k <= T_REV8; k++) rand_op(tb_op_t'(k));
    end_test("zbb single-cycle");

    begin_test();
    for (r = 0; r < ROUNDS; r++)
      for (k = T_SH1ADD; k <= T_SH3ADD; k++) rand_op(tb_op_t'(k));
    end_test("shift-add");

    begin_test();
    for (r = 0; r < ROUNDS; r++)
      for (k = T_BCLR; k <= T_MAXU; k++) rand_op(tb_op_t'(k));
    end_test("single-bit and min/max");

    begin_test();
    for (k = T_ROL; k <= T_CPOP; k++) begin
      run_op(tb_op_t'(k), 32'h0000_0000, '0, 5'd7);  // clz/ctz give 32
      run_op(tb_op_t'(k), 32'hffff_ffff, '0, 5'd31);
    end
    for (r = 0; r < ROUNDS; r++)
      for (k = T_ROL; k <= T_CPOP; k++) rand_op(tb_op_t'(k));
    end_test("rotate and count");

    begin_test();
    for (r = 0; r < ROUNDS; r++)
      for (k = T_CLMUL; k <= T_CLMULR; k++) rand_op(tb_op_t'(k));
    end_test("carry-less multiply");

    begin_test();
    for (r = 0; r < ROUNDS; r++) rand_op(T_ILLEGAL);
    end_test("unmatched encoding");

    repeat (2) @(negedge clk);
    check_value("valid_o pulse count", valid_seen, NUM_OPS);
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // watchdog, every op bounded by MAX_WAIT cycles
  initial begin
    #(NUM_OPS * MAX_WAIT * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD);
    $display("timeout, the tests did not finish in the expected time");
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+test
hw/bitmanip_types_pkg.sv
hw/bitmanip_op_pkg.sv
hw/bitmanip_decoder.sv
hw/bitmanip_ctrl.sv
hw/bitmanip_serial_shifter.sv
hw/bitmanip_clmul.sv
hw/bitmanip_result_stage.sv
hw/bitmanip_top.sv
test/tb_bitmanip.sv

/* Bender.yml */
package:
  name: bitmanip

sources:
  # packages first, then the units, then the top level
  - files:
      - hw/bitmanip_types_pkg.sv
      - hw/bitmanip_op_pkg.sv
      - hw/bitmanip_decoder.sv
      - hw/bitmanip_ctrl.sv
      - hw/bitmanip_serial_shifter.sv
      - hw/bitmanip_clmul.sv
      - hw/bitmanip_result_stage.sv
      - hw/bitmanip_top.sv

  - target: test
    include_dirs:
      - test
    files:
      - test/tb_bitmanip.sv
